/* hdl/clock_pkg.sv */
package clock_pkg;

    ////////////////////////////////////////////////////////////////////
    // Widths and field limits
    ////////////////////////////////////////////////////////////////////

    localparam int FIELD_W = 7;
    localparam int TIME_W  = 3 * FIELD_W;

    localparam logic [FIELD_W-1:0] HOURS_MAX   = 7'd23;
    localparam logic [FIELD_W-1:0] MINUTES_MAX = 7'd59;
    localparam logic [FIELD_W-1:0] SECONDS_MAX = 7'd59;

    ////////////////////////////////////////////////////////////////////
    // Time word, read raw or split into fields
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [FIELD_W-1:0] hours;
        logic [FIELD_W-1:0] minutes;
        logic [FIELD_W-1:0] seconds;
    } time_fields_t;

    typedef union packed {
        logic [TIME_W-1:0] raw;
        time_fields_t      fields;
    } time_word_u;

    typedef enum logic [1:0] {
        FIELD_NONE    = 2'd0,
        FIELD_HOURS   = 2'd1,
        FIELD_MINUTES = 2'd2,
        FIELD_SECONDS = 2'd3
    } field_e;

    typedef enum logic [2:0] {
        CLOCK_VIEW = 3'd0,
        SET_CLOCK  = 3'd1,
        ALARM_VIEW = 3'd2,
        SET_ALARM  = 3'd3,
        RINGING    = 3'd4
    } mode_e;

    // One step up or down, wrapping inside 0..max_val
    function automatic logic [FIELD_W-1:0] field_step(
        input logic [FIELD_W-1:0] value,
        input logic [FIELD_W-1:0] max_val,
        input logic               up
    );
        if (up) begin
            return (value == max_val) ? '0 : value + 1'b1;
        end
        return (value == '0) ? max_val : value - 1'b1;
    endfunction

endpackage

/* hdl/tick_divider.sv */
`timescale 1ns/1ns

module tick_divider #(
    parameter int TICK_DIV = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // Free running, keeps the seconds phase through every mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == LAST);
            if (cnt == LAST) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/button_edges.sv */
`timescale 1ns/1ns

module button_edges (
    input  logic clk,
    input  logic rst_n,
    input  logic mode,
    input  logic set,
    input  logic op1,
    input  logic op2,
    output logic mode_pulse,
    output logic set_pulse,
    output logic op1_pulse,
    output logic op2_pulse
);

    logic [3:0] level;
    logic [3:0] level_q;
    logic [3:0] pulse_q;

    assign level = {mode, set, op1, op2};

    // Rising edge of each button, one cycle wide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
            pulse_q <= '0;
        end else begin
            level_q <= level;
            pulse_q <= level & ~level_q;
        end
    end

    assign mode_pulse = pulse_q[3];
    assign set_pulse  = pulse_q[2];
    assign op1_pulse  = pulse_q[1];
    assign op2_pulse  = pulse_q[0];

endmodule

/* hdl/timekeeper.sv */
`timescale 1ns/1ns

module timekeeper (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tick,
    input  logic                 run,
    input  logic                 op1_pulse,
    input  logic                 op2_pulse,
    input  clock_pkg::field_e    clock_field,
    output clock_pkg::time_word_u now_time
);

    import clock_pkg::*;

    logic step;
    logic last_second;
    logic last_minute;

    assign step        = op1_pulse | op2_pulse;
    assign last_second = (now_time.fields.seconds == SECONDS_MAX);
    assign last_minute = (now_time.fields.minutes == MINUTES_MAX);

    ////////////////////////////////////////////////////////////////////
    // Running count with carry
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            now_time.raw <= '0;
        end else if (run && tick) begin
            now_time.fields.seconds <= field_step(now_time.fields.seconds,
                                                  SECONDS_MAX, 1'b1);
            if (last_second) begin
                now_time.fields.minutes <= field_step(now_time.fields.minutes,
                                                      MINUTES_MAX, 1'b1);
                // 23:59:59 rolls over to midnight
                if (last_minute) begin
                    now_time.fields.hours <= field_step(now_time.fields.hours,
                                                        HOURS_MAX, 1'b1);
                end
            end
        end else if (step) begin
            // Manual adjust, no carry between fields
            case (clock_field)
                FIELD_HOURS: begin
                    now_time.fields.hours <= field_step(now_time.fields.hours,
                                                        HOURS_MAX, op1_pulse);
                end
                FIELD_MINUTES: begin
                    now_time.fields.minutes <= field_step(now_time.fields.minutes,
                                                          MINUTES_MAX, op1_pulse);
                end
                FIELD_SECONDS: begin
                    now_time.fields.seconds <= field_step(now_time.fields.seconds,
                                                          SECONDS_MAX, op1_pulse);
                end
                default: begin
                    now_time <= now_time;
                end
            endcase
        end
    end

endmodule

/* hdl/alarm_unit.sv */
`timescale 1ns/1ns

module alarm_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  op1_pulse,
    input  logic                  op2_pulse,
    input  logic                  arm,
    input  logic                  disarm,
    input  clock_pkg::field_e     alarm_field,
    input  clock_pkg::time_word_u now_time,
    output clock_pkg::time_word_u alarm_time,
    output logic                  alarm_match
);

    import clock_pkg::*;

    logic [FIELD_W-1:0] alarm_hours;
    logic [FIELD_W-1:0] alarm_minutes;
    logic               armed;

    // Hours and minutes only, seconds never set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alarm_hours   <= '0;
            alarm_minutes <= '0;
        end else if (op1_pulse || op2_pulse) begin
            case (alarm_field)
                FIELD_HOURS: begin
                    alarm_hours <= field_step(alarm_hours, HOURS_MAX, op1_pulse);
                end
                FIELD_MINUTES: begin
                    alarm_minutes <= field_step(alarm_minutes, MINUTES_MAX, op1_pulse);
                end
                default: begin
                    alarm_hours <= alarm_hours;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else if (disarm) begin
            armed <= 1'b0;
        end else if (arm) begin
            armed <= 1'b1;
        end
    end

    always_comb begin
        alarm_time                = '0;
        alarm_time.fields.hours   = alarm_hours;
        alarm_time.fields.minutes = alarm_minutes;
    end

    // Matches for the whole minute while armed
    assign alarm_match = armed
                       && (now_time.fields.hours == alarm_hours)
                       && (now_time.fields.minutes == alarm_minutes);

endmodule

/* hdl/mode_fsm.sv */
`timescale 1ns/1ns

module mode_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mode_pulse,
    input  logic                         set_pulse,
    input  logic                         op1_pulse,
    input  logic                         op2_pulse,
    input  logic                         alarm_match,
    input  clock_pkg::time_word_u        now_time,
    input  clock_pkg::time_word_u        alarm_time,
    output logic                         run,
    output logic                         arm,
    output logic                         disarm,
    output logic                         display,
    output logic [2:0]                   flash,
    output clock_pkg::field_e            clock_field,
    output clock_pkg::field_e            alarm_field,
    output logic [clock_pkg::TIME_W-1:0] out_time
);

    import clock_pkg::*;

    mode_e  state;
    mode_e  state_d;
    field_e field_q;
    field_e field_d;

    ////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state;
        field_d = field_q;
        arm     = 1'b0;
        disarm  = 1'b0;
        case (state)
            CLOCK_VIEW: begin
                if (set_pulse) begin
                    state_d = SET_CLOCK;
                    field_d = FIELD_HOURS;
                end else if (mode_pulse) begin
                    state_d = ALARM_VIEW;
                end else if (alarm_match) begin
                    state_d = RINGING;
                end
            end
            SET_CLOCK: begin
                if (set_pulse) begin
                    case (field_q)
                        FIELD_HOURS:   field_d = FIELD_MINUTES;
                        FIELD_MINUTES: field_d = FIELD_SECONDS;
                        default: begin
                            state_d = CLOCK_VIEW;
                            field_d = FIELD_NONE;
                        end
                    endcase
                end else if (mode_pulse) begin
                    state_d = ALARM_VIEW;
                    field_d = FIELD_NONE;
                end
            end
            ALARM_VIEW: begin
                if (set_pulse) begin
                    state_d = SET_ALARM;
                    field_d = FIELD_HOURS;
                end else if (mode_pulse) begin
                    state_d = CLOCK_VIEW;
                end else if (op2_pulse) begin
                    disarm = 1'b1;
                end
            end
            SET_ALARM: begin
                if (set_pulse) begin
                    if (field_q == FIELD_HOURS) begin
                        field_d = FIELD_MINUTES;
                    end else begin
                        // Leaving minutes commits the alarm
                        arm     = 1'b1;
                        state_d = ALARM_VIEW;
                        field_d = FIELD_NONE;
                    end
                end else if (mode_pulse) begin
                    state_d = CLOCK_VIEW;
                    field_d = FIELD_NONE;
                end
            end
            RINGING: begin
                if (op2_pulse) begin
                    disarm  = 1'b1;
                    state_d = CLOCK_VIEW;
                end
            end
            default: begin
                state_d = CLOCK_VIEW;
                field_d = FIELD_NONE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CLOCK_VIEW;
            field_q <= FIELD_NONE;
        end else begin
            state   <= state_d;
            field_q <= field_d;
        end
    end

    // 12/24 flag, kept across modes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display <= 1'b0;
        end else if (op1_pulse && (state == CLOCK_VIEW || state == ALARM_VIEW)) begin
            display <= ~display;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////

    assign run = (state == CLOCK_VIEW) || (state == ALARM_VIEW) || (state == RINGING);

    assign clock_field = (state == SET_CLOCK) ? field_q : FIELD_NONE;
    assign alarm_field = (state == SET_ALARM) ? field_q : FIELD_NONE;

    always_comb begin
        flash = 3'b000;
        if (state == RINGING) begin
            flash = 3'b111;
        end else if (state == SET_CLOCK || state == SET_ALARM) begin
            case (field_q)
                FIELD_HOURS:   flash = 3'b100;
                FIELD_MINUTES: flash = 3'b010;
                FIELD_SECONDS: flash = 3'b001;
                default:       flash = 3'b000;
            endcase
        end
    end

    // Always the 24-hour value, display only hints the format
    assign out_time = (state == ALARM_VIEW || state == SET_ALARM) ? alarm_time.raw
                                                                  : now_time.raw;

endmodule

/* hdl/digital_clock.sv */
`timescale 1ns/1ns

module digital_clock #(
    parameter int TICK_DIV = 50_000_000
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mode,
    input  logic                         set,
    input  logic                         op1,
    input  logic                         op2,
    output logic                         display,
    output logic [2:0]                   flash,
    output logic [clock_pkg::TIME_W-1:0] out_time
);

    import clock_pkg::*;

    logic       tick;
    logic       mode_pulse;
    logic       set_pulse;
    logic       op1_pulse;
    logic       op2_pulse;
    logic       run;
    logic       arm;
    logic       disarm;
    logic       alarm_match;
    field_e     clock_field;
    field_e     alarm_field;
    time_word_u now_time;
    time_word_u alarm_time;

    tick_divider #(
        .TICK_DIV (TICK_DIV)
    ) u_tick_divider (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    button_edges u_button_edges (
        .clk        (clk),
        .rst_n      (rst_n),
        .mode       (mode),
        .set        (set),
        .op1        (op1),
        .op2        (op2),
        .mode_pulse (mode_pulse),
        .set_pulse  (set_pulse),
        .op1_pulse  (op1_pulse),
        .op2_pulse  (op2_pulse)
    );

    timekeeper u_timekeeper (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .run         (run),
        .op1_pulse   (op1_pulse),
        .op2_pulse   (op2_pulse),
        .clock_field (clock_field),
        .now_time    (now_time)
    );

    alarm_unit u_alarm_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .op1_pulse   (op1_pulse),
        .op2_pulse   (op2_pulse),
        .arm         (arm),
        .disarm      (disarm),
        .alarm_field (alarm_field),
        .now_time    (now_time),
        .alarm_time  (alarm_time),
        .alarm_match (alarm_match)
    );

    mode_fsm u_mode_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode_pulse  (mode_pulse),
        .set_pulse   (set_pulse),
        .op1_pulse   (op1_pulse),
        .op2_pulse   (op2_pulse),
        .alarm_match (alarm_match),
        .now_time    (now_time),
        .alarm_time  (alarm_time),
        .run         (run),
        .arm         (arm),
        .disarm      (disarm),
        .display     (display),
        .flash       (flash),
        .clock_field (clock_field),
        .alarm_field (alarm_field),
        .out_time    (out_time)
    );

endmodule

/* test/tb_digital_clock.sv */
`timescale 1ns/1ns

module tb_digital_clock;

    import clock_pkg::*;

    localparam int DIV   = 4;
    localparam int LIMIT = DIV * 86402 + 6000;

    logic              clk;
    logic              rst_n;
    logic              mode;
    logic              set;
    logic              op1;
    logic              op2;
    logic              display;
    logic [2:0]        flash;
    logic [TIME_W-1:0] out_time;

    int          cycles;
    int          rel;
    int          base_n;
    int          last_act;
    bit          running;
    bit          exp_display;
    time_word_u  base;
    time_word_u  alarm_w;
    logic [31:0] lfsr;

    digital_clock #(.TICK_DIV(DIV)) UUT (
        .clk(clk), .rst_n(rst_n), .mode(mode), .set(set), .op1(op1), .op2(op2),
        .display(display), .flash(flash), .out_time(out_time)
    );

    initial begin
        clk = 1'b0;
        cycles = 0;
        forever begin
            #10;
            clk = 1'b1;
            cycles = cycles + 1;
            if (cycles > LIMIT) begin
                $display("Timeout: the run went past its cycle limit");
                $display("Test failed");
                $fatal(1, "Cycle limit reached");
            end
            #10;
            clk = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////

    function automatic time_word_u add_seconds(time_word_u w, int n);
        int total;
        time_word_u r;
        total = w.fields.hours * 3600 + w.fields.minutes * 60 + w.fields.seconds + n;
        total = total % 86400;
        r.fields.hours   = 7'(total / 3600);
        r.fields.minutes = 7'((total / 60) % 60);
        r.fields.seconds = 7'(total % 60);
        return r;
    endfunction

    function automatic logic [6:0] step_field(logic [6:0] v, int max, bit up);
        return 7'(up ? (v + 1) % (max + 1) : (v + max) % (max + 1));
    endfunction

    function automatic time_word_u bump(time_word_u w, int f, bit up);
        case (f)
            1: w.fields.hours = step_field(w.fields.hours, 23, up);
            2: w.fields.minutes = step_field(w.fields.minutes, 59, up);
            default: w.fields.seconds = step_field(w.fields.seconds, 59, up);
        endcase
        return w;
    endfunction

    function automatic logic [2:0] flash_for(int f);
        case (f)
            1: return 3'b100;
            2: return 3'b010;
            3: return 3'b001;
            4: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    // Ticks land on edges m with m % DIV == 1 starting at DIV + 1
    function automatic int count_ticks(int a, int b);
        return (b + DIV - 1) / DIV - (a + DIV - 1) / DIV;
    endfunction

    function automatic time_word_u expected_now(int n);
        return running ? add_seconds(base, count_ticks(base_n, n)) : base;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_rand(input int k, output int v);
        v = 0;
        repeat (k) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        rel = cycles;
        base = '0;
        base_n = 1;
        running = 1'b1;
        alarm_w = '0;
        exp_display = 1'b0;
    endtask

    // Button index selects mode, set, op1 or op2
    // DUT acts two edges after the rise
    task automatic press(input int which);
        @(posedge clk);
        case (which)
            0: mode <= 1'b1;
            1: set <= 1'b1;
            2: op1 <= 1'b1;
            default: op2 <= 1'b1;
        endcase
        repeat (2) @(posedge clk);
        mode <= 1'b0;
        set <= 1'b0;
        op1 <= 1'b0;
        op2 <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        last_act = cycles - rel - 3;
    endtask

    task automatic freeze();
        base = add_seconds(base, count_ticks(base_n, last_act));
        running = 1'b0;
    endtask

    task automatic resume();
        base_n = last_act;
        running = 1'b1;
    endtask

    task automatic run_cycles(input int k, input logic [2:0] fl, input bit show_alarm);
        time_word_u exp_t;
        repeat (k) begin
            @(negedge clk);
            exp_t = show_alarm ? alarm_w : expected_now(cycles - rel);
            check("out_time", 32'(out_time), 32'(exp_t.raw));
            check("flash", 32'(flash), 32'(fl));
            check("display", 32'(display), 32'(exp_display));
        end
    endtask

    task automatic random_adjust(input int f, input bit alarm);
        int n_up;
        int n_dn;
        get_rand(3, n_up);
        get_rand(3, n_dn);
        repeat (n_up) begin
            press(2);
            if (alarm) alarm_w = bump(alarm_w, f, 1'b1);
            else base = bump(base, f, 1'b1);
            run_cycles(1, flash_for(f), alarm);
        end
        repeat (n_dn) begin
            press(3);
            if (alarm) alarm_w = bump(alarm_w, f, 1'b0);
            else base = bump(base, f, 1'b0);
            run_cycles(1, flash_for(f), alarm);
        end
    endtask

    // Arms the alarm for 00:01 and returns to clock view
    task automatic arm_next_minute(input bit cancel_first);
        press(0);
        press(1);
        freeze();
        press(1);
        press(2);
        alarm_w.fields.minutes = 7'd1;
        press(1);
        resume();
        if (cancel_first) press(3);
        press(0);
    endtask

    task automatic watch_minute(input bit may_ring);
        time_word_u prev;
        bit ringing;
        int after;
        ringing = 1'b0;
        after = 0;
        while (after < 6) begin
            prev = expected_now(cycles - rel);
            if (may_ring && prev.fields.minutes == 7'd1) ringing = 1'b1;
            run_cycles(1, ringing ? 3'b111 : 3'b000, 1'b0);
            if (ringing || prev.fields.minutes == 7'd2) after = after + 1;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        mode = 1'b0;
        set = 1'b0;
        op1 = 1'b0;
        op2 = 1'b0;
        lfsr = 32'h9ece;

        // Free run through a full day and the midnight wrap
        do_reset();
        run_cycles(DIV * 86401 + 4, 3'b000, 1'b0);

        // Clock setting field by field
        do_reset();
        press(1);
        freeze();
        run_cycles(8, 3'b100, 1'b0);
        for (int f = 1; f <= 3; f++) begin
            random_adjust(f, 1'b0);
            press(1);
        end
        resume();
        run_cycles(40, 3'b000, 1'b0);

        // 12/24 flag
        do_reset();
        repeat (3) begin
            press(2);
            exp_display = ~exp_display;
            run_cycles(4, 3'b000, 1'b0);
        end
        press(0);
        run_cycles(4, 3'b000, 1'b1);

        // Alarm view and setting
        do_reset();
        press(0);
        run_cycles(4, 3'b000, 1'b1);
        press(1);
        freeze();
        for (int f = 1; f <= 2; f++) begin
            random_adjust(f, 1'b1);
            press(1);
        end
        resume();
        run_cycles(2, 3'b000, 1'b1);
        press(3);
        press(0);
        run_cycles(8, 3'b000, 1'b0);

        // Alarm rings, is cancelled, and a disarmed alarm stays quiet
        do_reset();
        arm_next_minute(1'b0);
        watch_minute(1'b1);
        press(3);
        watch_minute(1'b0);
        do_reset();
        arm_next_minute(1'b1);
        watch_minute(1'b0);

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* flist.f */
hdl/clock_pkg.sv
hdl/tick_divider.sv
hdl/button_edges.sv
hdl/timekeeper.sv
hdl/alarm_unit.sv
hdl/mode_fsm.sv
hdl/digital_clock.sv
test/tb_digital_clock.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_digital_clock -f flist.f -o sim_tb
out=$(./obj_dir/sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1
